// ==== hdl/speck_pkg.sv ====
// speck lab target definitions
package speck_pkg;

   ////////////////////
   // widths and types
   ////////////////////
   localparam int BLOCK_W   = 64;    // one cipher block
   localparam int KEY_W     = 128;   // 4 key words
   localparam int WORD_W    = 32;    // half block
   localparam int ROUNDS    = 27;    // 64/128 variant, one stage per round
   localparam int ADDR_W    = 6;     // register address
   localparam int BYTECNT_W = 4;     // byte index within a register

   typedef logic [BLOCK_W-1:0] block_t;   // {x, y}, x in the high word
   typedef logic [KEY_W-1:0]   key_t;     // {l2, l1, l0, k0}

   ////////////////////
   // fifo sizing
   ////////////////////
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_PTR_W = 3;   // log2 of depth

   ////////////////////
   // cipher constants
   ////////////////////
   localparam int ALPHA = 8;   // right rotate of x
   localparam int BETA  = 3;   // left rotate of y

   ////////////////////
   // register map
   ////////////////////
   localparam logic [ADDR_W-1:0] REG_IDENTIFY    = 6'h04;
   localparam logic [ADDR_W-1:0] REG_GO          = 6'h05;   // write pulses go
   localparam logic [ADDR_W-1:0] REG_TEXTIN      = 6'h06;   // 8 bytes
   localparam logic [ADDR_W-1:0] REG_CIPHEROUT   = 6'h07;   // read head, write pops
   localparam logic [ADDR_W-1:0] REG_KEY         = 6'h0a;   // 16 bytes, byte 0 lsb
   localparam logic [ADDR_W-1:0] REG_WRITE_PT    = 6'h10;   // write pushes textin
   localparam logic [ADDR_W-1:0] REG_STATUS      = 6'h11;
   localparam logic [ADDR_W-1:0] REG_FIFO_ERRORS = 6'h12;   // any write clears

   localparam logic [7:0] IDENTIFY_VAL = 8'h5c;

   // sticky error bits in REG_FIFO_ERRORS
   localparam int ERR_IN_OVF  = 0;
   localparam int ERR_OUT_OVF = 1;
   localparam int ERR_OUT_UNF = 2;

endpackage

// ==== hdl/cdc_pulse.sv ====
// toggle pulse synchronizer
`timescale 1ns/1ps

module cdc_pulse (
   input  logic reset_i,
   input  logic src_clk,
   input  logic src_pulse,
   input  logic dst_clk,
   output logic dst_pulse
);

   logic       src_tog;    // flips once per source pulse
   logic [2:0] dst_sync;   // two sync flops plus one for edge detect

   // source side
   always_ff @(posedge src_clk) begin
      if (reset_i)
         src_tog <= 1'b0;
      else if (src_pulse)
         src_tog <= ~src_tog;
   end

   // destination side
   always_ff @(posedge dst_clk) begin
      if (reset_i)
         dst_sync <= 3'b000;
      else
         dst_sync <= {dst_sync[1:0], src_tog};
   end

   // any change of the synced toggle is one pulse
   assign dst_pulse = dst_sync[2] ^ dst_sync[1];

endmodule

// ==== hdl/block_fifo.sv ====
// first word fall through block fifo
`timescale 1ns/1ps

module block_fifo import speck_pkg::*; (
   input  logic   crypto_clk,
   input  logic   reset_i,
   input  logic   push,
   input  block_t push_data,
   input  logic   pop,
   output block_t head,        // oldest entry
   output logic   empty,
   output logic   full,
   output logic   overflow,    // push dropped
   output logic   underflow    // pop while empty
);

   block_t                mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_PTR_W:0]   count;     // one extra bit for full
   logic                  do_push;
   logic                  do_pop;

   assign empty = (count == 0);
   assign full  = (count == FIFO_DEPTH);

   assign do_pop  = pop & ~empty;
   assign do_push = push & (~full | do_pop);   // full with pop still takes data

   assign head = mem[rd_ptr];

   // storage
   always_ff @(posedge crypto_clk) begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   // pointers, occupancy, strobes
   always_ff @(posedge crypto_clk) begin
      if (reset_i) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         overflow  <= 1'b0;
         underflow <= 1'b0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         overflow  <= push & ~do_push;
         underflow <= pop & empty;
      end
   end

endmodule

// ==== hdl/speck_engine.sv ====
// speck 64/128 round pipeline
`timescale 1ns/1ps

module speck_engine import speck_pkg::*; (
   input  logic   crypto_clk,
   input  logic   reset_i,
   input  logic   go,
   input  key_t   key,
   input  logic   fifo_empty,
   input  block_t fifo_head,
   output logic   fifo_pop,
   output logic   result_valid,
   output block_t result,
   output logic   busy
);

   logic              drain_q;           // burst in progress
   logic [ROUNDS-1:0] vld_q;             // one valid per stage
   block_t            blk_q [ROUNDS];    // state after round s
   key_t              ks_q  [ROUNDS-1];  // schedule for round s+1

   function automatic logic [WORD_W-1:0] ror(input logic [WORD_W-1:0] w, input int n);
      return (w >> n) | (w << (WORD_W - n));
   endfunction

   function automatic logic [WORD_W-1:0] rol(input logic [WORD_W-1:0] w, input int n);
      return (w << n) | (w >> (WORD_W - n));
   endfunction

   // one encryption round with round key k
   function automatic block_t speck_round(input block_t b, input logic [WORD_W-1:0] k);
      logic [WORD_W-1:0] x;
      logic [WORD_W-1:0] y;
      x = (ror(b[BLOCK_W-1:WORD_W], ALPHA) + b[WORD_W-1:0]) ^ k;
      y = rol(b[WORD_W-1:0], BETA) ^ x;
      return {x, y};
   endfunction

   // schedule state {l[i+2], l[i+1], l[i], k[i]} -> next, i is round index
   function automatic key_t ks_step(input key_t ks, input int i);
      logic [WORD_W-1:0] l_new;
      logic [WORD_W-1:0] k_new;
      l_new = (ks[WORD_W-1:0] + ror(ks[2*WORD_W-1:WORD_W], ALPHA)) ^ i[WORD_W-1:0];
      k_new = rol(ks[WORD_W-1:0], BETA) ^ l_new;
      return {l_new, ks[4*WORD_W-1:3*WORD_W], ks[3*WORD_W-1:2*WORD_W], k_new};
   endfunction

   ////////////////////
   // burst feeder
   ////////////////////
   assign fifo_pop = drain_q & ~fifo_empty;   // one block per cycle

   always_ff @(posedge crypto_clk) begin
      if (reset_i)
         drain_q <= 1'b0;
      else if (go)
         drain_q <= 1'b1;
      else if (fifo_empty)
         drain_q <= 1'b0;   // input drained
   end

   ////////////////////
   // pipeline
   ////////////////////
   always_ff @(posedge crypto_clk) begin
      if (reset_i)
         vld_q <= '0;
      else
         vld_q <= {vld_q[ROUNDS-2:0], fifo_pop};
   end

   // payload only moves with its valid
   always_ff @(posedge crypto_clk) begin
      if (fifo_pop) begin
         blk_q[0] <= speck_round(fifo_head, key[WORD_W-1:0]);   // k0 from current key
         ks_q[0]  <= ks_step(key, 0);
      end
      for (int s = 1; s < ROUNDS; s++) begin
         if (vld_q[s-1])
            blk_q[s] <= speck_round(blk_q[s-1], ks_q[s-1][WORD_W-1:0]);
      end
      for (int s = 1; s < ROUNDS - 1; s++) begin
         if (vld_q[s-1])
            ks_q[s] <= ks_step(ks_q[s-1], s);   // last stage needs no next key
      end
   end

   assign result_valid = vld_q[ROUNDS-1];   // ROUNDS cycles after pop
   assign result       = blk_q[ROUNDS-1];
   assign busy         = drain_q | (|vld_q);

endmodule

// ==== hdl/speck_reg.sv ====
// host register file
`timescale 1ns/1ps

module speck_reg import speck_pkg::*; (
   input  logic                 usb_clk,
   input  logic                 crypto_clk,
   input  logic                 reset_i,
   // host bus, usb_clk
   input  logic [ADDR_W-1:0]    reg_address,
   input  logic [BYTECNT_W-1:0] reg_bytecnt,
   input  logic [7:0]           write_data,
   output logic [7:0]           read_data,     // one cycle after reg_read
   input  logic                 reg_read,
   input  logic                 reg_write,
   input  logic                 reg_addrvalid,
   // crypto_clk outputs
   output key_t                 key,
   output block_t               textin,
   output logic                 push_pt,
   output logic                 go,
   output logic                 pop_ct,
   // crypto_clk inputs
   input  logic                 exttrigger_in,
   input  block_t               cipher_head,
   input  logic                 out_empty,
   input  logic                 in_empty,
   input  logic                 busy,
   input  logic                 in_overflow,
   input  logic                 out_overflow,
   input  logic                 out_underflow
);

   key_t       key_q;          // usb side key
   block_t     text_q;         // usb side text
   logic [7:0] rd_mux;
   logic       wr_en;

   logic       push_usb;       // one usb cycle command pulses
   logic       go_usb;
   logic       pop_usb;
   logic       clr_usb;
   logic       go_crypto;
   logic       clr_crypto;

   key_t       key_meta;       // usb -> crypto captures
   key_t       key_sync;
   block_t     text_meta;
   block_t     text_sync;

   block_t     ct_meta;        // crypto -> usb captures
   block_t     ct_sync;
   logic [2:0] stat_meta;
   logic [2:0] stat_sync;
   logic [2:0] err_meta;
   logic [2:0] err_sync;

   logic       trig_m;         // exttrigger sync and edge
   logic       trig_s;
   logic       trig_r;
   logic [2:0] err_q;          // sticky, crypto domain

   assign wr_en = reg_addrvalid & reg_write;

   ////////////////////
   // read side
   ////////////////////
   always_comb begin
      rd_mux = 8'h00;
      if (reg_addrvalid && reg_read) begin
         case (reg_address)
            REG_IDENTIFY:    rd_mux = IDENTIFY_VAL;
            REG_KEY:         rd_mux = key_q[reg_bytecnt*8 +: 8];
            REG_TEXTIN:      rd_mux = text_q[reg_bytecnt[2:0]*8 +: 8];
            REG_CIPHEROUT:   rd_mux = ct_sync[reg_bytecnt[2:0]*8 +: 8];
            REG_STATUS:      rd_mux = {5'b0, stat_sync};   // busy, in empty, out empty
            REG_FIFO_ERRORS: rd_mux = {5'b0, err_sync};
            default:         rd_mux = 8'h00;
         endcase
      end
   end

   always_ff @(posedge usb_clk) begin
      if (reset_i)
         read_data <= 8'h00;
      else
         read_data <= rd_mux;   // registered, 0 when idle
   end

   ////////////////////
   // write side
   ////////////////////
   always_ff @(posedge usb_clk) begin
      if (wr_en && reg_address == REG_KEY)
         key_q[reg_bytecnt*8 +: 8] <= write_data;
      if (wr_en && reg_address == REG_TEXTIN)
         text_q[reg_bytecnt[2:0]*8 +: 8] <= write_data;
   end

   // command strobes, data byte ignored
   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         push_usb <= 1'b0;
         go_usb   <= 1'b0;
         pop_usb  <= 1'b0;
         clr_usb  <= 1'b0;
      end else begin
         push_usb <= wr_en && (reg_address == REG_WRITE_PT);
         go_usb   <= wr_en && (reg_address == REG_GO);
         pop_usb  <= wr_en && (reg_address == REG_CIPHEROUT);
         clr_usb  <= wr_en && (reg_address == REG_FIFO_ERRORS);
      end
   end

   // crypto -> usb, quasi static
   always_ff @(posedge usb_clk) begin
      ct_meta   <= cipher_head;
      ct_sync   <= ct_meta;
      stat_meta <= {busy, in_empty, out_empty};
      stat_sync <= stat_meta;
      err_meta  <= err_q;
      err_sync  <= err_meta;
   end

   ////////////////////
   // crypto side
   ////////////////////
   cdc_pulse i_push_cdc (
      .reset_i   (reset_i),
      .src_clk   (usb_clk),
      .src_pulse (push_usb),
      .dst_clk   (crypto_clk),
      .dst_pulse (push_pt)
   );

   cdc_pulse i_go_cdc (
      .reset_i   (reset_i),
      .src_clk   (usb_clk),
      .src_pulse (go_usb),
      .dst_clk   (crypto_clk),
      .dst_pulse (go_crypto)
   );

   cdc_pulse i_pop_cdc (
      .reset_i   (reset_i),
      .src_clk   (usb_clk),
      .src_pulse (pop_usb),
      .dst_clk   (crypto_clk),
      .dst_pulse (pop_ct)
   );

   cdc_pulse i_clr_cdc (
      .reset_i   (reset_i),
      .src_clk   (usb_clk),
      .src_pulse (clr_usb),
      .dst_clk   (crypto_clk),
      .dst_pulse (clr_crypto)
   );

   // key and text only change while idle
   always_ff @(posedge crypto_clk) begin
      key_meta  <= key_q;
      key_sync  <= key_meta;
      text_meta <= text_q;
      text_sync <= text_meta;
   end

   assign key    = key_sync;
   assign textin = text_sync;

   // external trigger, two flops then rising edge
   always_ff @(posedge crypto_clk) begin
      if (reset_i)
         {trig_r, trig_s, trig_m} <= 3'b000;
      else
         {trig_r, trig_s, trig_m} <= {trig_s, trig_m, exttrigger_in};
   end

   assign go = go_crypto | (trig_s & ~trig_r);

   // sticky errors, clear then set
   always_ff @(posedge crypto_clk) begin
      if (reset_i || clr_crypto)
         err_q <= 3'b000;
      else begin
         if (in_overflow)   err_q[ERR_IN_OVF]  <= 1'b1;
         if (out_overflow)  err_q[ERR_OUT_OVF] <= 1'b1;
         if (out_underflow) err_q[ERR_OUT_UNF] <= 1'b1;
      end
   end

endmodule

// ==== hdl/speck_top.sv ====
// speck lab target top level
`timescale 1ns/1ps

module speck_top import speck_pkg::*; (
   input  logic                 usb_clk,
   input  logic                 crypto_clk,
   input  logic                 reset_i,
   input  logic [ADDR_W-1:0]    reg_address,
   input  logic [BYTECNT_W-1:0] reg_bytecnt,
   input  logic [7:0]           write_data,
   output logic [7:0]           read_data,
   input  logic                 reg_read,
   input  logic                 reg_write,
   input  logic                 reg_addrvalid,
   input  logic                 exttrigger_in
);

   key_t   key;
   block_t textin;
   logic   push_pt;         // crypto pulses from host
   logic   go;
   logic   pop_ct;

   block_t in_head;         // input fifo to engine
   logic   in_empty;
   logic   in_overflow;
   logic   fifo_pop;

   logic   result_valid;    // engine to output fifo
   block_t result;
   logic   busy;

   block_t cipher_head;
   logic   out_empty;
   logic   out_overflow;
   logic   out_underflow;

   speck_reg i_reg (
      .usb_clk       (usb_clk),
      .crypto_clk    (crypto_clk),
      .reset_i       (reset_i),
      .reg_address   (reg_address),
      .reg_bytecnt   (reg_bytecnt),
      .write_data    (write_data),
      .read_data     (read_data),
      .reg_read      (reg_read),
      .reg_write     (reg_write),
      .reg_addrvalid (reg_addrvalid),
      .key           (key),
      .textin        (textin),
      .push_pt       (push_pt),
      .go            (go),
      .pop_ct        (pop_ct),
      .exttrigger_in (exttrigger_in),
      .cipher_head   (cipher_head),
      .out_empty     (out_empty),
      .in_empty      (in_empty),
      .busy          (busy),
      .in_overflow   (in_overflow),
      .out_overflow  (out_overflow),
      .out_underflow (out_underflow)
   );

   // plaintext queue, engine never pops it empty
   block_fifo i_in_fifo (
      .crypto_clk (crypto_clk),
      .reset_i    (reset_i),
      .push       (push_pt),
      .push_data  (textin),
      .pop        (fifo_pop),
      .head       (in_head),
      .empty      (in_empty),
      .full       (),
      .overflow   (in_overflow),
      .underflow  ()
   );

   speck_engine i_engine (
      .crypto_clk   (crypto_clk),
      .reset_i      (reset_i),
      .go           (go),
      .key          (key),
      .fifo_empty   (in_empty),
      .fifo_head    (in_head),
      .fifo_pop     (fifo_pop),
      .result_valid (result_valid),
      .result       (result),
      .busy         (busy)
   );

   // ciphertext queue, popped by host
   block_fifo i_out_fifo (
      .crypto_clk (crypto_clk),
      .reset_i    (reset_i),
      .push       (result_valid),
      .push_data  (result),
      .pop        (pop_ct),
      .head       (cipher_head),
      .empty      (out_empty),
      .full       (),
      .overflow   (out_overflow),
      .underflow  (out_underflow)
   );

endmodule

// ==== test/speck_chk.sv ====
// engine protocol assertions
`timescale 1ns/1ps

module speck_chk import speck_pkg::*; (
   input logic crypto_clk,
   input logic reset_i,
   input logic go,
   input logic fifo_pop,
   input logic fifo_empty,
   input logic result_valid,
   input logic busy
);

   logic failed = 1'b0;   // set by any failing property

   // a burst pops every cycle until the input fifo runs dry
   a_burst_pops: assert property (@(posedge crypto_clk) disable iff (reset_i)
      (go || fifo_pop) |=> (fifo_pop || fifo_empty))
      else begin
         $error("burst stopped popping a non empty input fifo");
         failed = 1'b1;
      end

   // fixed pipeline depth in both directions
   a_pop_to_result: assert property (@(posedge crypto_clk) disable iff (reset_i)
      fifo_pop |-> ##ROUNDS result_valid)
      else begin
         $error("result missing ROUNDS cycles after pop");
         failed = 1'b1;
      end

   a_result_from_pop: assert property (@(posedge crypto_clk) disable iff (reset_i)
      result_valid |-> $past(fifo_pop, ROUNDS))
      else begin
         $error("result without a pop ROUNDS cycles earlier");
         failed = 1'b1;
      end

   // idle right out of reset
   a_idle_after_reset: assert property (@(posedge crypto_clk)
      $fell(reset_i) |-> !busy)
      else begin
         $error("engine busy after reset");
         failed = 1'b1;
      end

endmodule

bind speck_engine speck_chk i_speck_chk (
   .crypto_clk   (crypto_clk),
   .reset_i      (reset_i),
   .go           (go),
   .fifo_pop     (fifo_pop),
   .fifo_empty   (fifo_empty),
   .result_valid (result_valid),
   .busy         (busy)
);

// ==== test/tb_speck.sv ====
// speck lab target testbench
`timescale 1ns/1ps

module tb_speck import speck_pkg::*; ();

   localparam int POLL_LIMIT = 300;   // status reads before giving up
   localparam int GAP_CRYPTO = 8;     // command spacing well over 4 crypto cycles

   // known answer vector from the speck paper
   localparam key_t   KAT_KEY = 128'h1b1a1918_13121110_0b0a0908_03020100;
   localparam block_t KAT_PT  = 64'h3b726574_7475432d;
   localparam block_t KAT_CT  = 64'h8c6fa548_454e028b;

   logic                 crypto_clk;
   logic                 usb_clk;
   logic                 reset_i;
   logic [ADDR_W-1:0]    reg_address;
   logic [BYTECNT_W-1:0] reg_bytecnt;
   logic [7:0]           write_data;
   logic [7:0]           read_data;
   logic                 reg_read;
   logic                 reg_write;
   logic                 reg_addrvalid;
   logic                 exttrigger_in;

   speck_top i_speck_top (
      .usb_clk       (usb_clk),
      .crypto_clk    (crypto_clk),
      .reset_i       (reset_i),
      .reg_address   (reg_address),
      .reg_bytecnt   (reg_bytecnt),
      .write_data    (write_data),
      .read_data     (read_data),
      .reg_read      (reg_read),
      .reg_write     (reg_write),
      .reg_addrvalid (reg_addrvalid),
      .exttrigger_in (exttrigger_in)
   );

   ////////////////////
   // clocks
   ////////////////////
   initial begin
      crypto_clk = 1'b0;
      forever #20 crypto_clk = ~crypto_clk;   // 40 ns
   end

   initial begin
      usb_clk = 1'b0;
      forever #15 usb_clk = ~usb_clk;   // 30 ns
   end

   ////////////////////
   // reference model
   ////////////////////
   // rotations fixed by the 64/128 variant with alpha 8 and beta 3
   function automatic logic [WORD_W-1:0] rotr8(input logic [WORD_W-1:0] w);
      return {w[7:0], w[WORD_W-1:8]};
   endfunction

   function automatic logic [WORD_W-1:0] rotl3(input logic [WORD_W-1:0] w);
      return {w[WORD_W-4:0], w[WORD_W-1:WORD_W-3]};
   endfunction

   // full key expansion first and then the rounds
   function automatic block_t speck_encrypt(input key_t k, input block_t pt);
      logic [WORD_W-1:0] l  [ROUNDS+2];
      logic [WORD_W-1:0] rk [ROUNDS];
      logic [WORD_W-1:0] x;
      logic [WORD_W-1:0] y;
      rk[0] = k[31:0];
      l[0]  = k[63:32];
      l[1]  = k[95:64];
      l[2]  = k[127:96];
      for (int i = 0; i < ROUNDS - 1; i++) begin
         l[i+3]  = (rk[i] + rotr8(l[i])) ^ 32'(i);
         rk[i+1] = rotl3(rk[i]) ^ l[i+3];
      end
      x = pt[63:32];   // x is the high word
      y = pt[31:0];
      for (int r = 0; r < ROUNDS; r++) begin
         x = (rotr8(x) + y) ^ rk[r];
         y = rotl3(y) ^ x;
      end
      return {x, y};
   endfunction

   ////////////////////
   // checks
   ////////////////////
   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_block(input string name, input block_t exp, input block_t act);
      if (exp !== act)
         fail_stop($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp, act));
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (exp !== act)
         fail_stop($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp, act));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act)
         fail_stop($sformatf("ERR t=%0t %s expected %b actual %b", $time, name, exp, act));
   endtask

   // bound engine checker
   always @(negedge crypto_clk) begin
      if (i_speck_top.i_engine.i_speck_chk.failed === 1'b1)
         fail_stop($sformatf("an engine assertion failed at %0t", $time));
   end

   ////////////////////
   // host bus
   ////////////////////
   task automatic reg_wr_byte(input logic [ADDR_W-1:0] addr, input int idx,
                              input logic [7:0] data);
      @(negedge usb_clk);
      reg_address   = addr;
      reg_bytecnt   = BYTECNT_W'(idx);
      write_data    = data;
      reg_write     = 1'b1;
      reg_addrvalid = 1'b1;
      @(negedge usb_clk);   // taken at the posedge between
      reg_write     = 1'b0;
      reg_addrvalid = 1'b0;
   endtask

   task automatic reg_rd_byte(input logic [ADDR_W-1:0] addr, input int idx,
                              output logic [7:0] data);
      @(negedge usb_clk);
      reg_address   = addr;
      reg_bytecnt   = BYTECNT_W'(idx);
      reg_read      = 1'b1;
      reg_addrvalid = 1'b1;
      @(negedge usb_clk);
      data          = read_data;   // registered one cycle after the request
      reg_read      = 1'b0;
      reg_addrvalid = 1'b0;
   endtask

   // lets a command cross and the usb side captures settle
   task automatic cmd_gap();
      repeat (GAP_CRYPTO) @(negedge crypto_clk);
      repeat (3) @(negedge usb_clk);
   endtask

   task automatic write_key(input key_t k);
      for (int b = 0; b < KEY_W / 8; b++)
         reg_wr_byte(REG_KEY, b, k[b*8 +: 8]);
      cmd_gap();
   endtask

   task automatic write_text(input block_t t);
      for (int b = 0; b < BLOCK_W / 8; b++)
         reg_wr_byte(REG_TEXTIN, b, t[b*8 +: 8]);
   endtask

   task automatic push_text(input block_t t);
      write_text(t);
      reg_wr_byte(REG_WRITE_PT, 0, 8'h00);
      cmd_gap();
   endtask

   task automatic start_go();
      reg_wr_byte(REG_GO, 0, 8'h00);
      cmd_gap();
   endtask

   // poll one status bit until it has the wanted value
   task automatic wait_status(input int pos, input logic val, input string what);
      logic [7:0] st;
      int         polls;
      polls = 0;
      reg_rd_byte(REG_STATUS, 0, st);
      while (st[pos] !== val) begin
         if (polls >= POLL_LIMIT)
            fail_stop($sformatf("timeout at %0t while waiting for %s", $time, what));
         polls++;
         reg_rd_byte(REG_STATUS, 0, st);
      end
   endtask

   // read the output fifo head and pop it
   task automatic read_cipher(output block_t ct);
      logic [7:0] d;
      wait_status(0, 1'b0, "a ciphertext in the output fifo");
      for (int b = 0; b < BLOCK_W / 8; b++) begin
         reg_rd_byte(REG_CIPHEROUT, b, d);
         ct[b*8 +: 8] = d;
      end
      reg_wr_byte(REG_CIPHEROUT, 0, 8'h00);   // pop
      cmd_gap();
   endtask

   task automatic check_idle(input string tag);
      logic [7:0] st;
      reg_rd_byte(REG_STATUS, 0, st);
      check_flag({tag, " status out empty"}, 1'b1, st[0]);
      check_flag({tag, " status in empty"}, 1'b1, st[1]);
      check_flag({tag, " status busy"}, 1'b0, st[2]);
   endtask

   ////////////////////
   // behaviors
   ////////////////////
   task automatic test_readback();
      key_t       k;
      block_t     t;
      logic [7:0] d;
      reg_rd_byte(REG_IDENTIFY, 0, d);
      check_byte("read_data identify", IDENTIFY_VAL, d);
      k = {$urandom, $urandom, $urandom, $urandom};
      t = {$urandom, $urandom};
      write_key(k);
      write_text(t);
      for (int b = 0; b < KEY_W / 8; b++) begin
         reg_rd_byte(REG_KEY, b, d);
         check_byte($sformatf("read_data key byte %0d", b), k[b*8 +: 8], d);
      end
      for (int b = 0; b < BLOCK_W / 8; b++) begin
         reg_rd_byte(REG_TEXTIN, b, d);
         check_byte($sformatf("read_data text byte %0d", b), t[b*8 +: 8], d);
      end
   endtask

   task automatic single_enc(input key_t k, input block_t pt, input string tag);
      block_t ct;
      write_key(k);
      push_text(pt);
      start_go();
      read_cipher(ct);
      check_block({tag, " ciphertext"}, speck_encrypt(k, pt), ct);
   endtask

   // n random blocks started by go or by the external trigger
   task automatic run_burst(input logic ext, input string tag);
      key_t   k;
      block_t pt;
      block_t ct;
      block_t exp_q [$];
      int     n;
      k = {$urandom, $urandom, $urandom, $urandom};
      n = $urandom_range(1, FIFO_DEPTH);
      write_key(k);
      for (int i = 0; i < n; i++) begin
         pt = {$urandom, $urandom};
         exp_q.push_back(speck_encrypt(k, pt));
         push_text(pt);
      end
      if (ext) begin
         @(negedge crypto_clk);
         exttrigger_in = 1'b1;
         repeat (4) @(negedge crypto_clk);   // long enough for the sync flops
         exttrigger_in = 1'b0;
         cmd_gap();
      end else begin
         start_go();
      end
      for (int i = 0; i < n; i++) begin
         read_cipher(ct);
         check_block($sformatf("%s ciphertext %0d", tag, i), exp_q.pop_front(), ct);
      end
      check_idle(tag);
   endtask

   task automatic test_errors();
      key_t       k;
      block_t     pt;
      block_t     ct;
      block_t     exp_q [$];
      logic [7:0] errs;
      k = {$urandom, $urandom, $urandom, $urandom};
      write_key(k);
      for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
         pt = {$urandom, $urandom};
         if (i < FIFO_DEPTH)
            exp_q.push_back(speck_encrypt(k, pt));   // last one is dropped
         push_text(pt);
      end
      reg_rd_byte(REG_FIFO_ERRORS, 0, errs);
      check_flag("err in overflow", 1'b1, errs[ERR_IN_OVF]);
      reg_wr_byte(REG_CIPHEROUT, 0, 8'h00);   // pop with nothing there
      cmd_gap();
      reg_rd_byte(REG_FIFO_ERRORS, 0, errs);
      check_byte("read_data fifo errors",
                 8'((1 << ERR_IN_OVF) | (1 << ERR_OUT_UNF)), errs);
      reg_wr_byte(REG_FIFO_ERRORS, 0, 8'h00);
      cmd_gap();
      reg_rd_byte(REG_FIFO_ERRORS, 0, errs);
      check_byte("read_data fifo errors cleared", 8'h00, errs);
      start_go();
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         read_cipher(ct);
         check_block($sformatf("overflow ciphertext %0d", i), exp_q.pop_front(), ct);
      end
      check_idle("overflow");
   endtask

   ////////////////////
   // main sequence
   ////////////////////
   initial begin
      reset_i       = 1'b1;
      reg_address   = '0;
      reg_bytecnt   = '0;
      write_data    = 8'h00;
      reg_read      = 1'b0;
      reg_write     = 1'b0;
      reg_addrvalid = 1'b0;
      exttrigger_in = 1'b0;
      void'($urandom(72293));
      repeat (5) @(posedge crypto_clk);
      @(negedge crypto_clk);
      reset_i = 1'b0;
      repeat (4) @(negedge usb_clk);

      check_block("model known answer", KAT_CT, speck_encrypt(KAT_KEY, KAT_PT));
      test_readback();
      single_enc(KAT_KEY, KAT_PT, "known answer");
      single_enc({$urandom, $urandom, $urandom, $urandom}, {$urandom, $urandom}, "single");
      run_burst(1'b0, "burst");
      run_burst(1'b1, "trigger");
      test_errors();

      $display("all tests passed");
      $finish;
   end

endmodule

// ==== tb.f ====
hdl/speck_pkg.sv
hdl/cdc_pulse.sv
hdl/block_fifo.sv
hdl/speck_engine.sv
hdl/speck_reg.sv
hdl/speck_top.sv
test/speck_chk.sv
test/tb_speck.sv
